// File: all.f
+incdir+dv
rtl/isa_pkg.sv
rtl/pipe_pkg.sv
rtl/issue_unit.sv
rtl/exec_lane.sv
rtl/writeback_regfile.sv
rtl/dual_issue_core.sv
dv/tb_dual_issue_core.sv

// File: dv/tb_program.svh
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

  // lane 0 word, lane 1 word, lane 0 value, lane 1 value and idle cycles after
  // enc_reg(op, rd, rs, rt), enc_imm(op, rt, rs, imm), enc_shift(op, rd, rs, shamt)
  localparam int PROG_LEN = 12;

  prog_entry_t prog [PROG_LEN];

  task automatic load_program();
    // untouched registers read zero after reset
    prog[0]  = '{enc_reg(isa_pkg::OP_ADD, 1, 5, 6), enc_reg(isa_pkg::OP_OR, 2, 31, 17),
                 32'h0000_0000, 32'h0000_0000, 4'd1};
    // immediates are zero-extended
    prog[1]  = '{enc_imm(isa_pkg::OP_ADDI, 1, 0, 'h1234), enc_imm(isa_pkg::OP_ORI, 2, 0, 'hf0f0),
                 32'h0000_1234, 32'h0000_f0f0, 4'd1};
    prog[2]  = '{enc_imm(isa_pkg::OP_ADDI, 3, 0, 'hffff), enc_imm(isa_pkg::OP_ORI, 4, 0, 'h8000),
                 32'h0000_ffff, 32'h0000_8000, 4'd1};
    prog[3]  = '{enc_reg(isa_pkg::OP_SUB, 5, 1, 3), enc_reg(isa_pkg::OP_AND, 6, 2, 3),
                 32'hffff_1235, 32'h0000_f0f0, 4'd1};
    // slt with a negative rs
    prog[4]  = '{enc_reg(isa_pkg::OP_XOR, 7, 1, 2), enc_reg(isa_pkg::OP_SLT, 8, 5, 1),
                 32'h0000_e2c4, 32'h0000_0001, 4'd1};
    prog[5]  = '{enc_shift(isa_pkg::OP_SLL, 9, 3, 16), enc_shift(isa_pkg::OP_SRL, 10, 5, 4),
                 32'hffff_0000, 32'h0fff_f123, 4'd0};
    // back to back, both lanes read the previous pair
    prog[6]  = '{enc_reg(isa_pkg::OP_SLT, 11, 9, 10), enc_reg(isa_pkg::OP_XOR, 12, 10, 4),
                 32'h0000_0001, 32'h0fff_7123, 4'd0};
    // forwarded and dependent through rt
    prog[7]  = '{enc_reg(isa_pkg::OP_ADD, 13, 11, 12), enc_reg(isa_pkg::OP_SUB, 14, 12, 13),
                 32'h0fff_7124, 32'hffff_ffff, 4'd0};
    // same dest in both lanes
    prog[8]  = '{enc_reg(isa_pkg::OP_ADD, 15, 1, 2), enc_reg(isa_pkg::OP_OR, 15, 3, 4),
                 32'h0001_0324, 32'h0000_ffff, 4'd0};
    prog[9]  = '{enc_reg(isa_pkg::OP_ADD, 16, 15, 0), enc_imm(isa_pkg::OP_ADDI, 17, 15, 'h1),
                 32'h0000_ffff, 32'h0001_0000, 4'd1};
    // r0 target and opcode 63, no commits
    prog[10] = '{enc_reg(isa_pkg::OP_ADD, 0, 1, 2), 32'hfc22_1800,
                 32'h0000_0000, 32'h0000_0000, 4'd1};
    // dependent shift through rs
    prog[11] = '{enc_reg(isa_pkg::OP_OR, 18, 0, 1), enc_shift(isa_pkg::OP_SLL, 19, 18, 4),
                 32'h0000_1234, 32'h0001_2340, 4'd1};
  endtask

`endif

// File: dv/tb_dual_issue_core.sv
`default_nettype none

module tb_dual_issue_core;

  localparam int CLK_PERIOD   = 40;
  localparam int RESET_CYCLES = 3;
  localparam int RAND_PAIRS   = 200;
  // expected-output ring, deeper than the longest commit latency
  localparam int SLOTS        = 8;

  // one directed pair with its hand-worked results
  typedef struct packed {
    isa_pkg::instr_t i0;
    isa_pkg::instr_t i1;
    isa_pkg::data_t  v0;
    isa_pkg::data_t  v1;
    logic [3:0]      gap;
  } prog_entry_t;

  logic                                      clk;
  logic                                      rst_n;
  logic                                      issue;
  isa_pkg::instr_t [pipe_pkg::NUM_LANES-1:0] issue_pair;
  logic                                      busy;
  pipe_pkg::wb_vec_t                         commit;

  // architectural state in program order
  isa_pkg::data_t     model_regs [isa_pkg::NUM_REGS];
  pipe_pkg::wb_item_t exp_commit [SLOTS][pipe_pkg::NUM_LANES];
  logic               exp_busy [SLOTS];
  int                 cyc;
  int                 errors;
  int                 checks;
  logic [31:0]        rng;

  dual_issue_core UUT (
    .clk        (clk),
    .rst_n      (rst_n),
    .issue      (issue),
    .issue_pair (issue_pair),
    .busy       (busy),
    .commit     (commit)
  );

  ////////////////////////////////////////////////////////////////////////////
  // instruction encoding and random source
  ////////////////////////////////////////////////////////////////////////////

  function automatic isa_pkg::instr_t enc_reg(isa_pkg::opcode_e op, int rd, int rs, int rt);
    return {op, 5'(rs), 5'(rt), 5'(rd), 5'd0, 6'd0};
  endfunction

  function automatic isa_pkg::instr_t enc_imm(isa_pkg::opcode_e op, int rt, int rs, int imm);
    return {op, 5'(rs), 5'(rt), 16'(imm)};
  endfunction

  function automatic isa_pkg::instr_t enc_shift(isa_pkg::opcode_e op, int rd, int rs, int sh);
    return {op, 5'(rs), 5'd0, 5'(rd), 5'(sh), 6'd0};
  endfunction

  function automatic logic [31:0] xorshift32(logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  `include "tb_program.svh"

  // 4 cycles per pair plus margin for reset and drain
  localparam int WATCHDOG_CYCLES = 4 * PROG_LEN + 4 * RAND_PAIRS + 20;

  // small register numbers so pairs collide often
  task automatic next_random_instr(output isa_pkg::instr_t w);
    logic [5:0] op;
    rng = xorshift32(rng);
    op  = 6'(rng[31:28] % 4'd12);
    w   = {op, 2'b00, rng[18:16], 2'b00, rng[21:19],
           rng[22] ? rng[15:0] : {2'b00, rng[13:0]}};
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // reference model
  ////////////////////////////////////////////////////////////////////////////

  // ISA semantics of one instruction, updates the model registers
  task automatic model_step(input isa_pkg::instr_t w, output pipe_pkg::wb_item_t res);
    logic [5:0]     opc;
    isa_pkg::data_t a;
    isa_pkg::data_t b;
    isa_pkg::data_t zimm;
    opc       = w[31:26];
    a         = model_regs[w[25:21]];
    b         = model_regs[w[20:16]];
    zimm      = {16'h0000, w[15:0]};
    res.valid = 1'b1;
    res.dest  = w[15:11];
    res.value = '0;
    case (opc)
      isa_pkg::OP_ADD: res.value = a + b;
      isa_pkg::OP_SUB: res.value = a - b;
      isa_pkg::OP_AND: res.value = a & b;
      isa_pkg::OP_OR:  res.value = a | b;
      isa_pkg::OP_XOR: res.value = a ^ b;
      isa_pkg::OP_SLT: res.value = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      isa_pkg::OP_SLL: res.value = a << w[10:6];
      isa_pkg::OP_SRL: res.value = a >> w[10:6];
      isa_pkg::OP_ADDI: begin
        res.value = a + zimm;
        res.dest  = w[20:16];
      end
      isa_pkg::OP_ORI: begin
        res.value = a | zimm;
        res.dest  = w[20:16];
      end
      default: res.valid = 1'b0;
    endcase
    // r0 writes are dropped
    if (res.dest == '0) begin
      res.valid = 1'b0;
    end
    if (res.valid) begin
      model_regs[res.dest] = res.value;
    end
  endtask

  // lane 1 reads the register that lane 0 writes
  function automatic logic needs_split(isa_pkg::instr_t w0, isa_pkg::instr_t w1);
    logic [5:0]        op0;
    logic [5:0]        op1;
    isa_pkg::reg_idx_t d0;
    logic              three_reg;
    op0       = w0[31:26];
    op1       = w1[31:26];
    d0        = (op0 == isa_pkg::OP_ADDI || op0 == isa_pkg::OP_ORI) ? w0[20:16] : w0[15:11];
    three_reg = (op1 >= isa_pkg::OP_ADD) && (op1 <= isa_pkg::OP_SLT);
    if (op0 == 6'd0 || op0 > isa_pkg::OP_ORI || d0 == '0) begin
      return 1'b0;
    end
    if (op1 == 6'd0 || op1 > isa_pkg::OP_ORI) begin
      return 1'b0;
    end
    return (w1[25:21] == d0) || (three_reg && (w1[20:16] == d0));
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // cycle checks and drive
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_cycle();
    int s;
    s = cyc % SLOTS;
    checks++;
    if (busy !== exp_busy[s]) begin
      $display("Error: busy expected %h got %h at cycle %0d", exp_busy[s], busy, cyc);
      errors++;
    end
    for (int l = 0; l < pipe_pkg::NUM_LANES; l++) begin
      if (commit[l].valid !== exp_commit[s][l].valid) begin
        $display("Error: commit[%0d].valid expected %h got %h at cycle %0d",
                 l, exp_commit[s][l].valid, commit[l].valid, cyc);
        errors++;
      end else if (exp_commit[s][l].valid) begin
        if (commit[l].dest !== exp_commit[s][l].dest) begin
          $display("Error: commit[%0d].dest expected %h got %h at cycle %0d",
                   l, exp_commit[s][l].dest, commit[l].dest, cyc);
          errors++;
        end
        if (commit[l].value !== exp_commit[s][l].value) begin
          $display("Error: commit[%0d].value expected %h got %h at cycle %0d",
                   l, exp_commit[s][l].value, commit[l].value, cyc);
          errors++;
        end
      end
      exp_commit[s][l] = '0;
    end
    exp_busy[s] = 1'b0;
  endtask

  // falling edge, outputs settled since the rising edge
  task automatic tick();
    @(negedge clk);
    cyc++;
    check_cycle();
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      tick();
      issue = 1'b0;
    end
  endtask

  // waits out busy, strobes one pair and books its commits
  task automatic send_pair(input isa_pkg::instr_t w0, input isa_pkg::instr_t w1,
                           output pipe_pkg::wb_item_t e0, output pipe_pkg::wb_item_t e1);
    logic split;
    tick();
    while (busy) begin
      issue = 1'b0;
      tick();
    end
    split = needs_split(w0, w1);
    model_step(w0, e0);
    model_step(w1, e1);
    issue         = 1'b1;
    issue_pair[0] = w0;
    issue_pair[1] = w1;
    // lane 0 two cycles out, a split lane 1 one more
    exp_commit[(cyc + 2) % SLOTS][0] = e0;
    exp_commit[(cyc + (split ? 3 : 2)) % SLOTS][1] = e1;
    if (split) begin
      exp_busy[(cyc + 1) % SLOTS] = 1'b1;
    end
  endtask

  initial begin
    clk = 1'b0;
    forever begin
      #(CLK_PERIOD / 2) clk = ~clk;
    end
  end

  initial begin
    pipe_pkg::wb_item_t e0;
    pipe_pkg::wb_item_t e1;
    isa_pkg::instr_t    w0;
    isa_pkg::instr_t    w1;
    rst_n      = 1'b0;
    issue      = 1'b0;
    issue_pair = '0;
    errors     = 0;
    checks     = 0;
    cyc        = 0;
    rng        = 32'h09a439e5;
    for (int r = 0; r < isa_pkg::NUM_REGS; r++) begin
      model_regs[r] = '0;
    end
    for (int s = 0; s < SLOTS; s++) begin
      exp_busy[s]      = 1'b0;
      exp_commit[s][0] = '0;
      exp_commit[s][1] = '0;
    end
    load_program();
    repeat (RESET_CYCLES) @(negedge clk);
    rst_n = 1'b1;
    // quiet outputs after reset
    idle(5);
    // directed pairs, model cross-checked against the table
    for (int n = 0; n < PROG_LEN; n++) begin
      send_pair(prog[n].i0, prog[n].i1, e0, e1);
      if (e0.valid && (e0.value !== prog[n].v0)) begin
        $display("Error: table entry %0d lane 0 value expected %h model %h",
                 n, prog[n].v0, e0.value);
        errors++;
      end
      if (e1.valid && (e1.value !== prog[n].v1)) begin
        $display("Error: table entry %0d lane 1 value expected %h model %h",
                 n, prog[n].v1, e1.value);
        errors++;
      end
      idle(int'(prog[n].gap));
    end
    // random pairs, 0 or 1 idle cycles between
    for (int n = 0; n < RAND_PAIRS; n++) begin
      next_random_instr(w0);
      next_random_instr(w1);
      send_pair(w0, w1, e0, e1);
      rng = xorshift32(rng);
      idle(rng[0] ? 1 : 0);
    end
    // drain the last commits
    idle(4);
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

  // watchdog
  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
    $display("checks %0d, errors %0d", checks, errors);
    $display("ERRORS FOUND");
    $finish;
  end

endmodule

`default_nettype wire

// File: rtl/dual_issue_core.sv
`default_nettype none

module dual_issue_core (
  input  wire logic                                        clk,
  input  wire logic                                        rst_n,
  input  wire logic                                        issue,
  input  wire isa_pkg::instr_t [pipe_pkg::NUM_LANES-1:0]   issue_pair,
  output logic                                             busy,
  output pipe_pkg::wb_vec_t                                commit
);

  // decode/execute slots
  wire pipe_pkg::lane_op_vec_t                            ops;
  // lane result registers, also the forwarding bus
  wire pipe_pkg::wb_vec_t                                 results;
  wire isa_pkg::reg_idx_t [pipe_pkg::NUM_READ_PORTS-1:0]  rd_addr;
  wire isa_pkg::data_t    [pipe_pkg::NUM_READ_PORTS-1:0]  rd_data;

  ////////////////////////////////////////////////////////////////////////////
  // issue
  ////////////////////////////////////////////////////////////////////////////

  issue_unit u_issue (
    .clk        (clk),
    .rst_n      (rst_n),
    .issue      (issue),
    .issue_pair (issue_pair),
    .busy       (busy),
    .rd_addr    (rd_addr),
    .rd_data    (rd_data),
    .ops        (ops)
  );

  ////////////////////////////////////////////////////////////////////////////
  // execute
  ////////////////////////////////////////////////////////////////////////////

  for (genvar i = 0; i < pipe_pkg::NUM_LANES; i++) begin : g_lane
    exec_lane u_lane (
      .clk     (clk),
      .rst_n   (rst_n),
      .op      (ops[i]),
      .results (results),
      .result  (results[i])
    );
  end

  // writeback
  writeback_regfile u_wb (
    .clk     (clk),
    .rst_n   (rst_n),
    .results (results),
    .rd_addr (rd_addr),
    .rd_data (rd_data)
  );

  // every register write is a commit record
  assign commit = results;

endmodule

`default_nettype wire

// File: rtl/exec_lane.sv
`default_nettype none

module exec_lane (
  input  wire logic               clk,
  input  wire logic               rst_n,
  input  wire pipe_pkg::lane_op_t op,
  input  wire pipe_pkg::wb_vec_t  results,
  output pipe_pkg::wb_item_t      result
);

  isa_pkg::data_t  src_a;
  isa_pkg::data_t  src_rt;
  isa_pkg::data_t  src_b;
  isa_pkg::shamt_t sh_amt;
  isa_pkg::data_t  alu_out;

  ////////////////////////////////////////////////////////////////////////////
  // operand forwarding
  ////////////////////////////////////////////////////////////////////////////

  // newest match wins, so lane 1 overrides lane 0
  // r0 never forwarded
  function automatic isa_pkg::data_t forward_src(isa_pkg::reg_idx_t  idx,
                                                 isa_pkg::data_t     read_val,
                                                 pipe_pkg::wb_vec_t  res);
    isa_pkg::data_t v;
    v = read_val;
    if (idx != '0) begin
      for (int l = 0; l < pipe_pkg::NUM_LANES; l++) begin
        if (res[l].valid && (res[l].dest == idx)) begin
          v = res[l].value;
        end
      end
    end
    return v;
  endfunction

  assign src_a  = forward_src(op.rs_idx, op.rs_val, results);
  assign src_rt = forward_src(op.rt_idx, op.rt_val, results);
  // immediate or shamt replaces rt
  assign src_b  = op.use_imm ? op.imm_val : src_rt;
  assign sh_amt = src_b[isa_pkg::SHAMT_W-1:0];

  ////////////////////////////////////////////////////////////////////////////
  // alu
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    case (op.alu_op)
      pipe_pkg::ALU_ADD: alu_out = src_a + src_b;
      pipe_pkg::ALU_SUB: alu_out = src_a - src_b;
      pipe_pkg::ALU_AND: alu_out = src_a & src_b;
      pipe_pkg::ALU_OR:  alu_out = src_a | src_b;
      pipe_pkg::ALU_XOR: alu_out = src_a ^ src_b;
      // signed compare, 0 or 1
      pipe_pkg::ALU_SLT: alu_out = isa_pkg::data_t'($signed(src_a) < $signed(src_b));
      pipe_pkg::ALU_SLL: alu_out = src_a << sh_amt;
      pipe_pkg::ALU_SRL: alu_out = src_a >> sh_amt;
      default:           alu_out = '0;
    endcase
  end

  // result register
  always_ff @(posedge clk) begin
    result.dest  <= op.dest;
    result.value <= alu_out;
    if (!rst_n) begin
      result.valid <= 1'b0;
    end else begin
      result.valid <= op.valid && op.writes;
    end
  end

  // decode must never hand over an r0 writer
  a_no_r0_result: assert property (@(posedge clk) disable iff (!rst_n)
    result.valid |-> (result.dest != '0));

endmodule

`default_nettype wire

// File: rtl/isa_pkg.sv
`default_nettype none

package isa_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // architectural widths
  ////////////////////////////////////////////////////////////////////////////

  localparam int DATA_W    = 32;
  localparam int REG_IDX_W = 5;
  localparam int NUM_REGS  = 1 << REG_IDX_W;
  localparam int INSTR_W   = 32;
  localparam int IMM_W     = 16;
  localparam int SHAMT_W   = 5;

  typedef logic [DATA_W-1:0]    data_t;
  typedef logic [REG_IDX_W-1:0] reg_idx_t;
  typedef logic [INSTR_W-1:0]   instr_t;
  typedef logic [IMM_W-1:0]     imm_t;
  typedef logic [SHAMT_W-1:0]   shamt_t;

  ////////////////////////////////////////////////////////////////////////////
  // instruction word fields
  ////////////////////////////////////////////////////////////////////////////

  localparam int OPCODE_MSB = 31;
  localparam int OPCODE_LSB = 26;
  localparam int RS_MSB     = 25;
  localparam int RS_LSB     = 21;
  localparam int RT_MSB     = 20;
  localparam int RT_LSB     = 16;
  localparam int RD_MSB     = 15;
  localparam int RD_LSB     = 11;
  localparam int SHAMT_MSB  = 10;
  localparam int SHAMT_LSB  = 6;
  localparam int IMM_MSB    = 15;
  localparam int IMM_LSB    = 0;

  // opcode map, codes not listed behave as nop
  // three-register ops read rs and rt, write rd
  // shifts read rs only, write rd, amount from shamt
  // immediate ops read rs, write rt
  typedef enum logic [OPCODE_MSB-OPCODE_LSB:0] {
    OP_NOP  = 6'd0,
    OP_ADD  = 6'd1,
    OP_SUB  = 6'd2,
    OP_AND  = 6'd3,
    OP_OR   = 6'd4,
    OP_XOR  = 6'd5,
    OP_SLT  = 6'd6,
    OP_SLL  = 6'd7,
    OP_SRL  = 6'd8,
    OP_ADDI = 6'd9,
    OP_ORI  = 6'd10
  } opcode_e;

endpackage

`default_nettype wire

// File: rtl/issue_unit.sv
`default_nettype none

module issue_unit (
  input  wire logic                                                 clk,
  input  wire logic                                                 rst_n,
  input  wire logic                                                 issue,
  input  wire isa_pkg::instr_t   [pipe_pkg::NUM_LANES-1:0]          issue_pair,
  output logic                                                      busy,
  output isa_pkg::reg_idx_t      [pipe_pkg::NUM_READ_PORTS-1:0]     rd_addr,
  input  wire isa_pkg::data_t    [pipe_pkg::NUM_READ_PORTS-1:0]     rd_data,
  output pipe_pkg::lane_op_vec_t                                    ops
);

  pipe_pkg::issue_state_e                      state;
  pipe_pkg::issue_state_e                      state_next;
  // lane 1 word parked across a split
  isa_pkg::instr_t                             held_instr;
  isa_pkg::instr_t [pipe_pkg::NUM_LANES-1:0]   lane_instr;
  pipe_pkg::lane_op_vec_t                      dec;
  pipe_pkg::lane_op_vec_t                      ops_next;
  logic                                        dependent;

  ////////////////////////////////////////////////////////////////////////////
  // decode
  ////////////////////////////////////////////////////////////////////////////

  function automatic pipe_pkg::lane_op_t decode_op(isa_pkg::instr_t w,
                                                   isa_pkg::data_t  rs_val,
                                                   isa_pkg::data_t  rt_val);
    pipe_pkg::lane_op_t op;
    isa_pkg::opcode_e   opc;
    isa_pkg::imm_t      imm;
    isa_pkg::shamt_t    shamt;
    opc   = isa_pkg::opcode_e'(w[isa_pkg::OPCODE_MSB:isa_pkg::OPCODE_LSB]);
    imm   = w[isa_pkg::IMM_MSB:isa_pkg::IMM_LSB];
    shamt = w[isa_pkg::SHAMT_MSB:isa_pkg::SHAMT_LSB];
    op        = '0;
    op.valid  = 1'b1;
    op.rs_idx = w[isa_pkg::RS_MSB:isa_pkg::RS_LSB];
    op.rt_idx = w[isa_pkg::RT_MSB:isa_pkg::RT_LSB];
    op.rs_val = rs_val;
    op.rt_val = rt_val;
    // rd by default, immediates retarget to rt
    op.dest   = w[isa_pkg::RD_MSB:isa_pkg::RD_LSB];
    case (opc)
      isa_pkg::OP_ADD: op.alu_op = pipe_pkg::ALU_ADD;
      isa_pkg::OP_SUB: op.alu_op = pipe_pkg::ALU_SUB;
      isa_pkg::OP_AND: op.alu_op = pipe_pkg::ALU_AND;
      isa_pkg::OP_OR:  op.alu_op = pipe_pkg::ALU_OR;
      isa_pkg::OP_XOR: op.alu_op = pipe_pkg::ALU_XOR;
      isa_pkg::OP_SLT: op.alu_op = pipe_pkg::ALU_SLT;
      isa_pkg::OP_SLL: begin
        op.alu_op  = pipe_pkg::ALU_SLL;
        op.use_imm = 1'b1;
        op.imm_val = isa_pkg::data_t'(shamt);
      end
      isa_pkg::OP_SRL: begin
        op.alu_op  = pipe_pkg::ALU_SRL;
        op.use_imm = 1'b1;
        op.imm_val = isa_pkg::data_t'(shamt);
      end
      isa_pkg::OP_ADDI: begin
        op.alu_op  = pipe_pkg::ALU_ADD;
        op.use_imm = 1'b1;
        op.imm_val = isa_pkg::data_t'(imm);
        op.dest    = op.rt_idx;
      end
      isa_pkg::OP_ORI: begin
        op.alu_op  = pipe_pkg::ALU_OR;
        op.use_imm = 1'b1;
        op.imm_val = isa_pkg::data_t'(imm);
        op.dest    = op.rt_idx;
      end
      isa_pkg::OP_NOP: op.valid = 1'b0;
      default:         op.valid = 1'b0;
    endcase
    // r0 target makes it a non-writer
    op.writes = op.valid && (op.dest != '0);
    return op;
  endfunction

  // lane 1 decodes the parked word while split
  always_comb begin
    lane_instr[0] = issue_pair[0];
    lane_instr[1] = (state == pipe_pkg::ISSUE_SPLIT) ? held_instr : issue_pair[1];
  end

  // ports 2i and 2i+1 belong to lane i
  always_comb begin
    for (int i = 0; i < pipe_pkg::NUM_LANES; i++) begin
      rd_addr[2*i]   = lane_instr[i][isa_pkg::RS_MSB:isa_pkg::RS_LSB];
      rd_addr[2*i+1] = lane_instr[i][isa_pkg::RT_MSB:isa_pkg::RT_LSB];
    end
  end

  always_comb begin
    for (int i = 0; i < pipe_pkg::NUM_LANES; i++) begin
      dec[i] = decode_op(lane_instr[i], rd_data[2*i], rd_data[2*i+1]);
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // steering
  ////////////////////////////////////////////////////////////////////////////

  // lane 1 reads what lane 0 writes
  // rt counts only for three-register ops
  assign dependent = dec[0].writes && dec[1].valid &&
                     ((dec[0].dest == dec[1].rs_idx) ||
                      (!dec[1].use_imm && (dec[0].dest == dec[1].rt_idx)));

  always_comb begin
    ops_next   = '0;
    state_next = state;
    if (state == pipe_pkg::ISSUE_SPLIT) begin
      // parked lane 1 goes out alone, keeps its slot
      ops_next[1] = dec[1];
      state_next  = pipe_pkg::ISSUE_PAIR;
    end else if (issue) begin
      ops_next[0] = dec[0];
      if (dependent) begin
        state_next = pipe_pkg::ISSUE_SPLIT;
      end else begin
        ops_next[1] = dec[1];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= pipe_pkg::ISSUE_PAIR;
      ops   <= '0;
    end else begin
      state <= state_next;
      ops   <= ops_next;
    end
  end

  // operands are re-read while parked, so only the word is kept
  always_ff @(posedge clk) begin
    if (state == pipe_pkg::ISSUE_PAIR) begin
      held_instr <= issue_pair[1];
    end
  end

  assign busy = (state == pipe_pkg::ISSUE_SPLIT);

  // environment must hold off for the split cycle
  a_no_issue_busy: assert property (@(posedge clk) disable iff (!rst_n)
    busy |-> !issue);

  // split lasts exactly one cycle
  a_split_once: assert property (@(posedge clk) disable iff (!rst_n)
    (state == pipe_pkg::ISSUE_SPLIT) |=> (state == pipe_pkg::ISSUE_PAIR));

endmodule

`default_nettype wire

// File: rtl/pipe_pkg.sv
`default_nettype none

package pipe_pkg;

  // two lanes, each with an rs and an rt read port
  localparam int NUM_LANES      = 2;
  localparam int NUM_READ_PORTS = 2 * NUM_LANES;

  // alu functions
  typedef enum logic [3:0] {
    ALU_ADD = 4'd0,
    ALU_SUB = 4'd1,
    ALU_AND = 4'd2,
    ALU_OR  = 4'd3,
    ALU_XOR = 4'd4,
    ALU_SLT = 4'd5,
    ALU_SLL = 4'd6,
    ALU_SRL = 4'd7
  } alu_op_e;

  ////////////////////////////////////////////////////////////////////////////
  // decode/execute slot, one per lane
  ////////////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic              valid;
    // set only for a writing op with nonzero dest
    logic              writes;
    alu_op_e           alu_op;
    isa_pkg::reg_idx_t rs_idx;
    isa_pkg::reg_idx_t rt_idx;
    isa_pkg::reg_idx_t dest;
    isa_pkg::data_t    rs_val;
    isa_pkg::data_t    rt_val;
    // second operand from imm_val instead of rt
    logic              use_imm;
    isa_pkg::data_t    imm_val;
  } lane_op_t;

  // result heading for regfile and commit port
  typedef struct packed {
    logic              valid;
    isa_pkg::reg_idx_t dest;
    isa_pkg::data_t    value;
  } wb_item_t;

  typedef wb_item_t [NUM_LANES-1:0] wb_vec_t;
  typedef lane_op_t [NUM_LANES-1:0] lane_op_vec_t;

  // issue fsm
  typedef enum logic {
    ISSUE_PAIR  = 1'b0,
    ISSUE_SPLIT = 1'b1
  } issue_state_e;

endpackage

`default_nettype wire

// File: rtl/writeback_regfile.sv
`default_nettype none

module writeback_regfile (
  input  wire logic                                          clk,
  input  wire logic                                          rst_n,
  input  wire pipe_pkg::wb_vec_t                             results,
  input  wire isa_pkg::reg_idx_t [pipe_pkg::NUM_READ_PORTS-1:0] rd_addr,
  output isa_pkg::data_t         [pipe_pkg::NUM_READ_PORTS-1:0] rd_data
);

  isa_pkg::data_t regs [isa_pkg::NUM_REGS];

  ////////////////////////////////////////////////////////////////////////////
  // write ports
  ////////////////////////////////////////////////////////////////////////////

  // later lane assigned last, lane 1 wins a shared dest
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int r = 0; r < isa_pkg::NUM_REGS; r++) begin
        regs[r] <= '0;
      end
    end else begin
      for (int l = 0; l < pipe_pkg::NUM_LANES; l++) begin
        if (results[l].valid) begin
          regs[results[l].dest] <= results[l].value;
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // read ports
  ////////////////////////////////////////////////////////////////////////////

  // write-through of this cycle's results
  // same lane priority as the write side
  always_comb begin
    for (int p = 0; p < pipe_pkg::NUM_READ_PORTS; p++) begin
      rd_data[p] = regs[rd_addr[p]];
      for (int l = 0; l < pipe_pkg::NUM_LANES; l++) begin
        if (results[l].valid && (results[l].dest == rd_addr[p])) begin
          rd_data[p] = results[l].value;
        end
      end
      // r0 hardwired
      if (rd_addr[p] == '0) begin
        rd_data[p] = '0;
      end
    end
  end

  // no write ever reaches r0
  a_r0_stays_zero: assert property (@(posedge clk) disable iff (!rst_n)
    regs[0] == '0);

endmodule

`default_nettype wire

// File: run.sh
#!/usr/bin/env bash
# build and run with Verilator, result decided from sim.log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module tb_dual_issue_core \
  -f all.f -o sim_tb > build.log 2>&1 &&
  ./obj_dir/sim_tb > sim.log 2>&1 ||
  { cat build.log sim.log 2>/dev/null; echo "build or simulation failed"; exit 1; }
cat sim.log
grep -q "ERRORS FOUND" sim.log && { echo "simulation failed"; exit 1; } ||
  echo "simulation passed"
